// File: rtl/cpu_settings.svh
// Widths and opcodes are fixed by the 6502 instruction set; only BRK and JMP abs decode outside group 01
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 8

// First opcode fetch after reset
`define RESET_VECTOR 16'h4000

// Opcodes decoded outside the accumulator group
`define OPCODE_BRK 8'h00
`define OPCODE_JMP_ABS 8'h4c

// cc field value of the accumulator group (aaabbbcc)
`define OPCODE_GROUP_ACC 2'b01

// Bit positions inside flags_t
`define FLAG_N 2
`define FLAG_Z 1
`define FLAG_C 0

`endif

// File: rtl/cpu_isa_pkg.sv
// Instruction set types for the accumulator group; enum values follow the 6502 aaa and bbb fields
`include "cpu_settings.svh"

package cpu_isa_pkg;

  // aaa field of group 01
  typedef enum logic [2:0] {
    ALU_ORA = 3'b000,
    ALU_AND = 3'b001,
    ALU_EOR = 3'b010,
    ALU_ADC = 3'b011,
    ALU_STA = 3'b100,
    ALU_LDA = 3'b101,
    ALU_CMP = 3'b110,
    ALU_SBC = 3'b111
  } alu_op_t;

  // bbb field, kept modes only
  typedef enum logic [2:0] {
    MODE_ZP  = 3'b001,
    MODE_IMM = 3'b010,
    MODE_ABS = 3'b011
  } addr_mode_t;

  typedef enum logic [2:0] {
    S_FETCH_OP,
    S_DECODE,
    S_FETCH_LO,
    S_FETCH_HI,
    S_READ_OP,
    S_EXECUTE,
    S_STORE,
    S_HALTED
  } seq_state_t;

  typedef logic [`DATA_W-1:0] opcode_t;
  typedef logic [1:0]         op_group_t;
  // Result with carry out on top
  typedef logic [`DATA_W:0]   alu_sum_t;
  // N, Z, C
  typedef logic [2:0]         flags_t;

endpackage

// File: rtl/cpu_bus_pkg.sv
// Memory side types; one 16-bit address space with 8-bit data, no byte strobes or error response
`include "cpu_settings.svh"

package cpu_bus_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;

  // APB requester phases
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_phase_t;

endpackage

// File: rtl/mem_bus_if.sv
// Request side holds req, addr, write and wdata until done pulses once, then drops req for a cycle
`timescale 1ns/1ns

interface mem_bus_if import cpu_bus_pkg::*; ();

  logic  req;
  logic  write;
  addr_t addr;
  data_t wdata;
  // Valid only while done is high
  data_t rdata;
  logic  done;

  modport requester (
    output req, write, addr, wdata,
    input  rdata, done
  );

  modport completer (
    input  req, write, addr, wdata,
    output rdata, done
  );

endinterface

// File: rtl/apb_requester.sv
// One transfer at a time; setup then access until pready, no pslverr, idle cycle after every transfer
`timescale 1ns/1ns

module apb_requester import cpu_bus_pkg::*;
(
  input  logic raw_clk,
  input  logic button_reset,
  mem_bus_if.completer mem,
  output logic psel,
  output logic penable,
  output logic pwrite,
  output addr_t paddr,
  output data_t pwdata,
  input  data_t prdata,
  input  logic pready
);

  apb_phase_t phase;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      phase <= APB_IDLE;
      pwrite <= 1'b0;
    end
    else
    begin
      case (phase)
        APB_IDLE:
          if (mem.req)
          begin
            phase <= APB_SETUP;
            pwrite <= mem.write;
          end
        APB_SETUP:
          phase <= APB_ACCESS;
        APB_ACCESS:
          // Wait states just stretch this phase
          if (pready)
          begin
            phase <= APB_IDLE;
            pwrite <= 1'b0;
          end
        default:
          phase <= APB_IDLE;
      endcase
    end
  end

  // Address and data held from setup through access
  always_ff @(posedge raw_clk)
  begin
    if (phase == APB_IDLE && mem.req)
    begin
      paddr <= mem.addr;
      pwdata <= mem.wdata;
    end
  end

  assign psel = (phase != APB_IDLE);
  assign penable = (phase == APB_ACCESS);

  assign mem.done = penable && pready;
  assign mem.rdata = prdata;

endmodule

// File: rtl/cpu_sequencer.sv
// Group 01 in zp, imm and abs plus JMP abs; BRK, STA imm and every other opcode halt until reset
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_sequencer import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
  input  logic raw_clk,
  input  logic button_reset,
  mem_bus_if.requester mem,
  input  data_t acc,
  output logic exec,
  output alu_op_t op,
  output data_t operand,
  output logic halted
);

  seq_state_t state;
  addr_t pc;
  addr_t ea;
  opcode_t ir;
  data_t lo_byte;

  addr_mode_t mode;
  op_group_t group;
  logic is_acc;
  logic is_jmp;
  logic is_sta;
  logic mem_state;

  // Instruction fields, aaabbbcc
  assign op = alu_op_t'(ir[7:5]);
  assign mode = addr_mode_t'(ir[4:2]);
  assign group = ir[1:0];
  assign is_acc = (group == `OPCODE_GROUP_ACC);
  assign is_jmp = (ir == `OPCODE_JMP_ABS);
  assign is_sta = is_acc && (op == ALU_STA);

  assign mem_state = (state == S_FETCH_OP) || (state == S_FETCH_LO) ||
                     (state == S_FETCH_HI) || (state == S_READ_OP) ||
                     (state == S_STORE);

  // Instruction stream from pc, data access at ea
  assign mem.addr = (state == S_READ_OP || state == S_STORE) ? ea : pc;
  assign mem.write = (state == S_STORE);
  assign mem.wdata = acc;

  assign exec = (state == S_EXECUTE) && is_acc;
  assign halted = (state == S_HALTED);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= S_FETCH_OP;
      pc <= `RESET_VECTOR;
      mem.req <= 1'b0;
    end
    else
    begin
      // One request per memory state, req low again the cycle after done
      if (mem.req)
      begin
        if (mem.done)
          mem.req <= 1'b0;
      end
      else if (mem_state)
        mem.req <= 1'b1;

      case (state)
        S_FETCH_OP:
          if (mem.done)
          begin
            ir <= mem.rdata;
            pc <= pc + 1'b1;
            state <= S_DECODE;
          end
        S_DECODE:
          if (ir == `OPCODE_BRK)
            state <= S_HALTED;
          else if (is_jmp)
            state <= S_FETCH_LO;
          else if (is_acc && (mode == MODE_ZP || mode == MODE_ABS))
            state <= S_FETCH_LO;
          else if (is_acc && mode == MODE_IMM && !is_sta)
            state <= S_FETCH_LO;
          else
            state <= S_HALTED;
        S_FETCH_LO:
          if (mem.done)
          begin
            pc <= pc + 1'b1;
            lo_byte <= mem.rdata;
            operand <= mem.rdata;
            // Zero page address, overwritten for absolute
            ea <= addr_t'(mem.rdata);
            if (is_jmp || mode == MODE_ABS)
              state <= S_FETCH_HI;
            else if (mode == MODE_IMM)
              state <= S_EXECUTE;
            else if (is_sta)
              state <= S_STORE;
            else
              state <= S_READ_OP;
          end
        S_FETCH_HI:
          if (mem.done)
          begin
            pc <= pc + 1'b1;
            ea <= {mem.rdata, lo_byte};
            if (is_jmp)
              state <= S_EXECUTE;
            else if (is_sta)
              state <= S_STORE;
            else
              state <= S_READ_OP;
          end
        S_READ_OP:
          if (mem.done)
          begin
            operand <= mem.rdata;
            state <= S_EXECUTE;
          end
        S_STORE:
          if (mem.done)
            state <= S_EXECUTE;
        S_EXECUTE:
        begin
          if (is_jmp)
            pc <= ea;
          state <= S_FETCH_OP;
        end
        default:
          state <= S_HALTED;
      endcase
    end
  end

endmodule

// File: rtl/accumulator_alu.sv
// Binary arithmetic only, no decimal mode or overflow flag; results land one cycle after exec
`timescale 1ns/1ns
`include "cpu_settings.svh"

module accumulator_alu import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
  input  logic raw_clk,
  input  logic button_reset,
  input  logic exec,
  input  alu_op_t op,
  input  data_t operand,
  output data_t acc,
  output flags_t flags
);

  alu_sum_t result;
  logic carry_next;

  always_comb
  begin
    carry_next = flags[`FLAG_C];
    case (op)
      ALU_ORA: result = {1'b0, acc | operand};
      ALU_AND: result = {1'b0, acc & operand};
      ALU_EOR: result = {1'b0, acc ^ operand};
      ALU_ADC:
      begin
        result = {1'b0, acc} + {1'b0, operand} + alu_sum_t'(flags[`FLAG_C]);
        carry_next = result[`DATA_W];
      end
      ALU_LDA: result = {1'b0, operand};
      ALU_CMP:
      begin
        // Carry set when no borrow, so A >= M
        result = {1'b0, acc} - {1'b0, operand};
        carry_next = !result[`DATA_W];
      end
      ALU_SBC:
      begin
        result = {1'b0, acc} - {1'b0, operand} - alu_sum_t'(!flags[`FLAG_C]);
        carry_next = !result[`DATA_W];
      end
      default: result = {1'b0, acc};
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      acc <= '0;
      flags <= '0;
    end
    else if (exec && op != ALU_STA)
    begin
      if (op != ALU_CMP)
        acc <= result[`DATA_W-1:0];
      flags[`FLAG_N] <= result[`DATA_W-1];
      flags[`FLAG_Z] <= (result[`DATA_W-1:0] == '0);
      flags[`FLAG_C] <= carry_next;
    end
  end

endmodule

// File: rtl/m6502_core.sv
// Runs straight on raw_clk; APB completer may insert any number of wait states, no error path
`timescale 1ns/1ns

module m6502_core import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
  input  logic raw_clk,
  input  logic button_reset,
  output logic psel,
  output logic penable,
  output logic pwrite,
  output addr_t paddr,
  output data_t pwdata,
  input  data_t prdata,
  input  logic pready,
  output data_t acc,
  output flags_t flags,
  output logic halted
);

  // Sequencer to ALU
  logic exec;
  alu_op_t op;
  data_t operand;

  mem_bus_if mem ();

  cpu_sequencer u_sequencer (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem          (mem.requester),
    .acc          (acc),
    .exec         (exec),
    .op           (op),
    .operand      (operand),
    .halted       (halted)
  );

  accumulator_alu u_alu (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .exec         (exec),
    .op           (op),
    .operand      (operand),
    .acc          (acc),
    .flags        (flags)
  );

  apb_requester u_apb (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem          (mem.completer),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready)
  );

endmodule

// File: bench/tb_clock.sv
// Free-running 8 ns raw_clk; button_reset held low for the first 16 rising edges
`timescale 1ns/1ns

module tb_clock
(
  output logic raw_clk,
  output logic button_reset
);

  initial
  begin
    raw_clk = 1'b0;
    forever
      #4 raw_clk = ~raw_clk;
  end

  // Released on a falling edge like the other inputs
  initial
  begin
    button_reset = 1'b0;
    repeat (16)
      @(posedge raw_clk);
    @(negedge raw_clk);
    button_reset = 1'b1;
  end

endmodule

// File: bench/m6502_chk.sv
// Bound into every m6502_core; checks APB phase order, signal stability and the halted bus
`timescale 1ns/1ns

module m6502_chk import cpu_bus_pkg::*;
(
  input logic raw_clk,
  input logic button_reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input addr_t paddr,
  input data_t pwdata,
  input logic pready,
  input logic halted
);

  // Setup lasts exactly one cycle
  setup_then_access: assert property (@(posedge raw_clk) disable iff (!button_reset)
    psel && !penable |=> psel && penable)
    else $error("APB setup cycle not followed by access");

  // Held from setup until the access that sees pready
  held_until_ready: assert property (@(posedge raw_clk) disable iff (!button_reset)
    psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else $error("APB address or data changed before pready");

  no_bus_when_halted: assert property (@(posedge raw_clk) disable iff (!button_reset)
    halted |-> !psel)
    else $error("psel raised while halted");

endmodule

bind m6502_core m6502_chk u_chk (
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .psel         (psel),
  .penable      (penable),
  .pwrite       (pwrite),
  .paddr        (paddr),
  .pwdata       (pwdata),
  .pready       (pready),
  .halted       (halted)
);

// File: bench/tb_m6502.sv
// Program and expected APB trace are built at time zero; memory model adds 0 to 3 wait states
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tb_m6502 import cpu_isa_pkg::*, cpu_bus_pkg::*; ();

  // One expected transfer; chk asks for an acc and flags check at an opcode fetch
  typedef struct packed {
    logic   chk;
    logic   write;
    addr_t  addr;
    data_t  wdata;
    data_t  acc;
    flags_t flags;
  } xfer_t;

  logic raw_clk;
  logic button_reset;
  logic psel;
  logic penable;
  logic pwrite;
  addr_t paddr;
  data_t pwdata;
  data_t prdata;
  logic pready;
  data_t acc;
  flags_t flags;
  logic halted;

  data_t ram [0:65535];
  data_t ref_mem [0:65535];
  xfer_t trace [$];
  logic [31:0] lfsr_state;
  addr_t m_pc;
  data_t m_acc;
  flags_t m_flags;
  data_t wait_left;
  int cycles;
  int cycle_limit;

  tb_clock u_clock (
    .raw_clk      (raw_clk),
    .button_reset (button_reset)
  );

  m6502_core UUT (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .acc          (acc),
    .flags        (flags),
    .halted       (halted)
  );

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
  endfunction

  // Up to 8 bits, one LFSR step per bit
  function automatic data_t rand_bits(input int n);
    data_t v;
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Expected {acc, N, Z, C} after one accumulator-group operation
  function automatic logic [10:0] alu_model(input alu_op_t op, input data_t a,
                                            input flags_t f, input data_t m);
    int r;
    logic c;
    data_t res;
    c = f[`FLAG_C];
    case (op)
      ALU_ORA: r = int'(a | m);
      ALU_AND: r = int'(a & m);
      ALU_EOR: r = int'(a ^ m);
      ALU_LDA: r = int'(m);
      ALU_ADC:
      begin
        r = int'(a) + int'(m) + int'(f[`FLAG_C]);
        c = (r > 255);
      end
      ALU_SBC:
      begin
        r = int'(a) - int'(m) - (1 - int'(f[`FLAG_C]));
        c = (r >= 0);
      end
      ALU_CMP:
      begin
        r = int'(a) - int'(m);
        c = (a >= m);
      end
      default:
        return {a, f};
    endcase
    res = r[7:0];
    if (op == ALU_CMP)
      return {a, res[7], res == 8'h00, c};
    return {res, res[7], res == 8'h00, c};
  endfunction

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic expect_equal(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    if (got !== exp)
      stop_on_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
  endtask

  task automatic load_byte(input addr_t a, input data_t d);
    ram[a] = d;
    ref_mem[a] = d;
  endtask

  task automatic queue_xfer(input logic chk, input logic write, input addr_t a, input data_t d);
    xfer_t x;
    x.chk = chk;
    x.write = write;
    x.addr = a;
    x.wdata = d;
    x.acc = m_acc;
    x.flags = m_flags;
    trace.push_back(x);
  endtask

  task automatic emit_byte(input data_t d, input logic is_opcode);
    load_byte(m_pc, d);
    queue_xfer(is_opcode, 1'b0, m_pc, 8'h00);
    m_pc = m_pc + 1'b1;
  endtask

  // Immediate operands travel in ea[7:0]
  task automatic add_acc_op(input alu_op_t op, input addr_mode_t mode, input addr_t ea);
    data_t m;
    m = 8'h00;
    emit_byte({op, mode, `OPCODE_GROUP_ACC}, 1'b1);
    emit_byte(ea[7:0], 1'b0);
    if (mode == MODE_ABS)
      emit_byte(ea[15:8], 1'b0);
    if (mode == MODE_IMM)
      m = ea[7:0];
    else if (op == ALU_STA)
    begin
      queue_xfer(1'b0, 1'b1, ea, m_acc);
      ref_mem[ea] = m_acc;
    end
    else
    begin
      m = ref_mem[ea];
      queue_xfer(1'b0, 1'b0, ea, 8'h00);
    end
    {m_acc, m_flags} = alu_model(op, m_acc, m_flags, m);
  endtask

  task automatic add_jmp(input addr_t target);
    emit_byte(`OPCODE_JMP_ABS, 1'b1);
    emit_byte(target[7:0], 1'b0);
    emit_byte(target[15:8], 1'b0);
    m_pc = target;
  endtask

  task automatic add_random_op(input logic imm_only);
    data_t r;
    alu_op_t op;
    r = rand_bits(3);
    op = alu_op_t'(r[2:0]);
    r = imm_only ? 8'h00 : rand_bits(2);
    if (r == 8'h01)
      add_acc_op(op, MODE_ZP, {8'h00, rand_bits(8)});
    else if (r == 8'h02)
      add_acc_op(op, MODE_ABS, {8'h80 | rand_bits(8), rand_bits(8)});
    else
      add_acc_op((op == ALU_STA) ? ALU_LDA : op, MODE_IMM, {8'h00, rand_bits(8)});
  endtask

  task automatic build_program();
    add_acc_op(ALU_LDA, MODE_IMM, 16'h0000);
    add_acc_op(ALU_ORA, MODE_IMM, {8'h00, rand_bits(8)});
    add_acc_op(ALU_AND, MODE_IMM, {8'h00, rand_bits(8)});
    add_acc_op(ALU_EOR, MODE_IMM, {8'h00, rand_bits(8)});
    add_acc_op(ALU_ADC, MODE_IMM, {8'h00, rand_bits(8)});
    add_acc_op(ALU_SBC, MODE_IMM, {8'h00, rand_bits(8)});
    add_acc_op(ALU_CMP, MODE_IMM, {8'h00, rand_bits(8)});
    for (int i = 0; i < 24; i++)
      add_random_op(1'b1);
    // Store then reload in both modes
    add_acc_op(ALU_STA, MODE_ZP, 16'h0040);
    add_acc_op(ALU_LDA, MODE_IMM, 16'h0055);
    add_acc_op(ALU_LDA, MODE_ZP, 16'h0040);
    add_acc_op(ALU_STA, MODE_ABS, 16'h9abc);
    add_acc_op(ALU_EOR, MODE_ABS, 16'h9abc);
    add_acc_op(ALU_CMP, MODE_ABS, 16'h8123);
    add_jmp(16'h4800);
    for (int i = 0; i < 40; i++)
      add_random_op(1'b0);
    emit_byte(`OPCODE_BRK, 1'b1);
  endtask

  // APB completer, inputs change on the falling edge only
  always @(negedge raw_clk)
  begin
    if (psel && !penable)
    begin
      wait_left = rand_bits(2);
      pready = 1'b0;
    end
    else if (psel && penable && wait_left == 8'h00)
    begin
      pready = 1'b1;
      if (pwrite)
        ram[paddr] = pwdata;
      else
        prdata = ram[paddr];
    end
    else if (psel && penable)
    begin
      wait_left = wait_left - 1'b1;
      pready = 1'b0;
    end
    else
      pready = 1'b0;
  end

  // One comparison per transfer, in its setup cycle
  always @(negedge raw_clk)
  begin : compare
    xfer_t x;
    if (button_reset && psel && !penable)
    begin
      if (trace.size() == 0)
        stop_on_failure("An APB transfer started after the expected trace was used up");
      else
      begin
        x = trace.pop_front();
        expect_equal("paddr", paddr, x.addr);
        expect_equal("pwrite", 16'(pwrite), 16'(x.write));
        if (x.write)
          expect_equal("pwdata", 16'(pwdata), 16'(x.wdata));
        if (x.chk)
        begin
          expect_equal("acc", 16'(acc), 16'(x.acc));
          expect_equal("flags", 16'(flags), 16'(x.flags));
        end
      end
    end
  end

  always @(posedge raw_clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
      stop_on_failure($sformatf("Timeout: the core did not halt within %0d cycles",
                                cycle_limit));
  end

  initial
  begin
    pready = 1'b0;
    prdata = 8'h00;
    wait_left = 8'h00;
    cycles = 0;
    lfsr_state = 32'hbbe0_9909;
    m_pc = `RESET_VECTOR;
    m_acc = 8'h00;
    m_flags = 3'b000;
    // Background pattern from the whole address
    for (int i = 0; i < 65536; i++)
      load_byte(addr_t'(i), i[15:8] ^ i[7:0] ^ 8'h3c);
    for (int i = 0; i < 256; i++)
      load_byte(addr_t'(i), rand_bits(8));
    build_program();
    // Worst transfer is about 8 cycles with decode and execute folded in
    cycle_limit = trace.size() * 8 + 16 + 32 + 64;

    @(posedge button_reset);
    expect_equal("psel", 16'(psel), 16'h0000);
    expect_equal("penable", 16'(penable), 16'h0000);
    expect_equal("pwrite", 16'(pwrite), 16'h0000);
    expect_equal("halted", 16'(halted), 16'h0000);
    expect_equal("acc", 16'(acc), 16'h0000);
    expect_equal("flags", 16'(flags), 16'h0000);

    while (!halted)
      @(negedge raw_clk);
    repeat (32)
    begin
      @(negedge raw_clk);
      expect_equal("psel", 16'(psel), 16'h0000);
    end

    if (trace.size() != 0)
      stop_on_failure($sformatf("%0d expected APB transfers never happened", trace.size()));
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/mem_bus_if.sv
rtl/apb_requester.sv
rtl/cpu_sequencer.sv
rtl/accumulator_alu.sv
rtl/m6502_core.sv
bench/tb_clock.sv
bench/m6502_chk.sv
bench/tb_m6502.sv

// File: run.sh
#!/bin/sh
# Builds and runs tb_m6502 with Verilator, then looks for the pass line in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_m6502 -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_m6502 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
